// ==== design/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int INSTR_W   = 32;
    localparam int REG_IDX_W = 5;
    localparam int FUNCT3_W  = 3;

    typedef logic [INSTR_W - 1:0]   instr_t;
    typedef logic [REG_IDX_W - 1:0] reg_idx_t;
    typedef logic [FUNCT3_W - 1:0]  funct3_t;

    localparam int OPCODE_MSB     = 6;
    localparam int RD_LSB         = 7;
    localparam int RD_MSB         = 11;
    localparam int FUNCT3_LSB     = 12;
    localparam int FUNCT3_MSB     = 14;
    localparam int RS1_LSB        = 15;
    localparam int RS1_MSB        = 19;
    localparam int RS2_LSB        = 20;
    localparam int RS2_MSB        = 24;
    localparam int FUNCT7_ALT_BIT = 30;  // funct7[5], picks SUB/SRA/SRAI
    localparam int ENV_BREAK_BIT  = 20;  // imm[0] of the system opcode, set for EBREAK

    typedef enum logic [OPCODE_MSB:0] {
        R_TYPE      = 7'b0110011,
        I_TYPE      = 7'b0010011,
        I_LOAD_TYPE = 7'b0000011,
        I_JALR_TYPE = 7'b1100111,
        I_ENV_TYPE  = 7'b1110011,
        S_TYPE      = 7'b0100011,
        B_TYPE      = 7'b1100011,
        U_LUI_TYPE  = 7'b0110111,
        U_AUI_TYPE  = 7'b0010111,
        J_TYPE      = 7'b1101111
    } opcode_e;

    // numeric codes are fixed, the test vectors store them as hex
    typedef enum logic [5:0] {
        OP_ADD    = 6'd0,  OP_SUB    = 6'd1,  OP_SLL    = 6'd2,  OP_SLT    = 6'd3,
        OP_SLTU   = 6'd4,  OP_XOR    = 6'd5,  OP_SRL    = 6'd6,  OP_SRA    = 6'd7,
        OP_OR     = 6'd8,  OP_AND    = 6'd9,
        OP_ADDI   = 6'd10, OP_SLLI   = 6'd11, OP_SLTI   = 6'd12, OP_SLTIU  = 6'd13,
        OP_XORI   = 6'd14, OP_SRLI   = 6'd15, OP_SRAI   = 6'd16, OP_ORI    = 6'd17,
        OP_ANDI   = 6'd18,
        OP_LB     = 6'd19, OP_LH     = 6'd20, OP_LW     = 6'd21, OP_LBU    = 6'd22,
        OP_LHU    = 6'd23,
        OP_SB     = 6'd24, OP_SH     = 6'd25, OP_SW     = 6'd26,
        OP_BEQ    = 6'd27, OP_BNE    = 6'd28, OP_BLT    = 6'd29, OP_BGE    = 6'd30,
        OP_BLTU   = 6'd31, OP_BGEU   = 6'd32,
        OP_JAL    = 6'd33, OP_JALR   = 6'd34,
        OP_LUI    = 6'd35, OP_AUIPC  = 6'd36,
        OP_ECALL  = 6'd37, OP_EBREAK = 6'd38,
        OP_NA     = 6'd63  // illegal or unsupported encoding
    } mnemonic_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLL = 4'd2,
        ALU_SLT = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SRL = 4'd5,
        ALU_SRA = 4'd6,
        ALU_OR  = 4'd7,
        ALU_AND = 4'd8
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_J = 3'd3,
        IMM_U = 3'd4
    } imm_sel_e;

    // item held between the mnemonic decoder and the control table
    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        funct3_t   funct3;
        mnemonic_e mnemonic;
        logic      alu_zero;
        logic      alu_slt;
    } decode_payload_t;

    // item held in the output stage
    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        funct3_t   funct3;
        mnemonic_e mnemonic;
        alu_op_e   alu_op;
        logic      alu_signed;
        logic      alu_src_a;
        logic      alu_src_b;
        logic      result_src;
        logic      mem_write;
        logic      reg_write;
        logic      pc_src;
        logic      illegal;
        imm_sel_e  imm_sel;
    } control_payload_t;

endpackage

// ==== design/rv_stage_reg.sv ====
`timescale 1ns/1ps

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // a slot opens when it is empty or its item leaves on this edge
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;  // drops to zero when drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;  // held otherwise, so a stalled item stays stable
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// ==== design/rv_mnemonic_decoder.sv ====
`timescale 1ns/1ps

module rv_mnemonic_decoder (
    input  rv_decode_pkg::instr_t    instruction,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::funct3_t   funct3,
    output rv_decode_pkg::mnemonic_e mnemonic
);

    import rv_decode_pkg::*;

    opcode_e opcode;
    logic    alt;    // funct7 bit 5
    logic    brk;    // set in EBREAK

    assign opcode = opcode_e'(instruction[OPCODE_MSB:0]);
    assign rd     = instruction[RD_MSB:RD_LSB];
    assign rs1    = instruction[RS1_MSB:RS1_LSB];
    assign rs2    = instruction[RS2_MSB:RS2_LSB];
    assign funct3 = instruction[FUNCT3_MSB:FUNCT3_LSB];
    assign alt    = instruction[FUNCT7_ALT_BIT];
    assign brk    = instruction[ENV_BREAK_BIT];

    always_comb begin
        mnemonic = OP_NA;  // anything not matched below is illegal
        case (opcode)
            R_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = alt ? OP_SUB : OP_ADD;
                    3'h1: mnemonic = OP_SLL;
                    3'h2: mnemonic = OP_SLT;
                    3'h3: mnemonic = OP_SLTU;
                    3'h4: mnemonic = OP_XOR;
                    3'h5: mnemonic = alt ? OP_SRA : OP_SRL;
                    3'h6: mnemonic = OP_OR;
                    default: mnemonic = OP_AND;
                endcase
            end
            I_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_ADDI;
                    3'h1: mnemonic = OP_SLLI;
                    3'h2: mnemonic = OP_SLTI;
                    3'h3: mnemonic = OP_SLTIU;
                    3'h4: mnemonic = OP_XORI;
                    3'h5: mnemonic = alt ? OP_SRAI : OP_SRLI;
                    3'h6: mnemonic = OP_ORI;
                    default: mnemonic = OP_ANDI;
                endcase
            end
            I_LOAD_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_LB;
                    3'h1: mnemonic = OP_LH;
                    3'h2: mnemonic = OP_LW;
                    3'h4: mnemonic = OP_LBU;
                    3'h5: mnemonic = OP_LHU;
                    default: mnemonic = OP_NA;  // 3, 6 and 7 are unused
                endcase
            end
            S_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_SB;
                    3'h1: mnemonic = OP_SH;
                    3'h2: mnemonic = OP_SW;
                    default: mnemonic = OP_NA;
                endcase
            end
            B_TYPE: begin
                case (funct3)
                    3'h0: mnemonic = OP_BEQ;
                    3'h1: mnemonic = OP_BNE;
                    3'h4: mnemonic = OP_BLT;
                    3'h5: mnemonic = OP_BGE;
                    3'h6: mnemonic = OP_BLTU;
                    3'h7: mnemonic = OP_BGEU;
                    default: mnemonic = OP_NA;
                endcase
            end
            I_JALR_TYPE: begin
                if (funct3 == 3'h0) begin
                    mnemonic = OP_JALR;
                end
            end
            I_ENV_TYPE: begin
                if (funct3 == 3'h0) begin  // the other funct3 values belong to CSR access
                    mnemonic = brk ? OP_EBREAK : OP_ECALL;
                end
            end
            U_LUI_TYPE: mnemonic = OP_LUI;
            U_AUI_TYPE: mnemonic = OP_AUIPC;
            J_TYPE:     mnemonic = OP_JAL;
            default:    mnemonic = OP_NA;
        endcase
    end

endmodule

// ==== design/rv_control_table.sv ====
`timescale 1ns/1ps

module rv_control_table (
    input  rv_decode_pkg::mnemonic_e mnemonic,
    input  logic                     alu_zero,
    input  logic                     alu_slt,
    output rv_decode_pkg::alu_op_e   alu_op,
    output logic                     alu_signed,
    output logic                     alu_src_a,
    output logic                     alu_src_b,
    output logic                     result_src,
    output logic                     mem_write,
    output logic                     reg_write,
    output logic                     pc_src,
    output logic                     illegal,
    output rv_decode_pkg::imm_sel_e  imm_sel
);

    import rv_decode_pkg::*;

    // datapath steering by instruction class
    always_comb begin
        alu_src_a  = 1'b0;
        alu_src_b  = 1'b0;
        result_src = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        illegal    = 1'b0;
        imm_sel    = IMM_I;
        case (mnemonic)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
            OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND: begin
                reg_write = 1'b1;  // both operands come from the register file
            end
            OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
            OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                reg_write  = 1'b1;
                alu_src_b  = 1'b1;
                result_src = 1'b1;  // write back the memory read data
            end
            OP_SB, OP_SH, OP_SW: begin
                mem_write = 1'b1;
                alu_src_b = 1'b1;
                imm_sel   = IMM_S;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                imm_sel = IMM_B;  // the ALU compares rs1 with rs2
            end
            OP_JAL: begin
                reg_write = 1'b1;  // link register gets pc + 4
                imm_sel   = IMM_J;
            end
            OP_JALR: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;  // target is rs1 + imm
            end
            OP_LUI: begin
                reg_write = 1'b1;
                alu_src_b = 1'b1;
                imm_sel   = IMM_U;
            end
            OP_AUIPC: begin
                reg_write = 1'b1;
                alu_src_a = 1'b1;  // pc on the first ALU operand
                alu_src_b = 1'b1;
                imm_sel   = IMM_U;
            end
            OP_ECALL, OP_EBREAK: begin
                illegal = 1'b0;  // legal, but nothing to drive in the datapath
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (mnemonic)
            OP_SUB, OP_BEQ, OP_BNE:            alu_op = ALU_SUB;  // equality tests via zero
            OP_SLL, OP_SLLI:                   alu_op = ALU_SLL;
            OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
            OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:  alu_op = ALU_SLT;
            OP_XOR, OP_XORI:                   alu_op = ALU_XOR;
            OP_SRL, OP_SRLI:                   alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:                   alu_op = ALU_SRA;
            OP_OR, OP_ORI:                     alu_op = ALU_OR;
            OP_AND, OP_ANDI:                   alu_op = ALU_AND;
            default:                           alu_op = ALU_ADD;  // address and link arithmetic too
        endcase
    end

    // signed compare only, shifts and loads leave this low
    assign alu_signed = (mnemonic == OP_SLT) || (mnemonic == OP_SLTI) ||
                        (mnemonic == OP_BLT) || (mnemonic == OP_BGE);

    // branch resolution from the flags of the same instruction
    always_comb begin
        case (mnemonic)
            OP_BEQ:           pc_src = alu_zero;
            OP_BNE:           pc_src = !alu_zero;
            OP_BLT, OP_BLTU:  pc_src = alu_slt;
            OP_BGE, OP_BGEU:  pc_src = !alu_slt;
            OP_JAL, OP_JALR:  pc_src = 1'b1;
            default:          pc_src = 1'b0;
        endcase
    end

endmodule

// ==== design/rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  rv_decode_pkg::instr_t    instruction,
    input  logic                     alu_zero,
    input  logic                     alu_slt,
    output logic                     out_valid,
    input  logic                     out_ready,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::funct3_t   funct3,
    output rv_decode_pkg::mnemonic_e mnemonic,
    output rv_decode_pkg::alu_op_e   alu_op,
    output logic                     alu_signed,
    output logic                     alu_src_a,
    output logic                     alu_src_b,
    output logic                     result_src,
    output logic                     mem_write,
    output logic                     reg_write,
    output logic                     pc_src,
    output logic                     illegal,
    output rv_decode_pkg::imm_sel_e  imm_sel
);

    import rv_decode_pkg::*;

    reg_idx_t         dec_rs1;
    reg_idx_t         dec_rs2;
    reg_idx_t         dec_rd;
    funct3_t          dec_funct3;
    mnemonic_e        dec_mnemonic;
    decode_payload_t  dec_in;
    decode_payload_t  dec_out;
    logic             dec_valid;
    logic             dec_ready;

    alu_op_e          ctl_alu_op;
    logic             ctl_alu_signed;
    logic             ctl_alu_src_a;
    logic             ctl_alu_src_b;
    logic             ctl_result_src;
    logic             ctl_mem_write;
    logic             ctl_reg_write;
    logic             ctl_pc_src;
    logic             ctl_illegal;
    imm_sel_e         ctl_imm_sel;
    control_payload_t ctl_in;
    control_payload_t ctl_out;

    rv_mnemonic_decoder rv_mnemonic_decoder_inst (
        .instruction (instruction),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .funct3      (dec_funct3),
        .mnemonic    (dec_mnemonic)
    );

    // the flags travel with their instruction into the first stage
    assign dec_in = '{rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd, funct3: dec_funct3,
                      mnemonic: dec_mnemonic, alu_zero: alu_zero, alu_slt: alu_slt};

    rv_stage_reg #(.payload_t(decode_payload_t)) rv_stage_reg_decode_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_in),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_out)
    );

    rv_control_table rv_control_table_inst (
        .mnemonic   (dec_out.mnemonic),
        .alu_zero   (dec_out.alu_zero),
        .alu_slt    (dec_out.alu_slt),
        .alu_op     (ctl_alu_op),
        .alu_signed (ctl_alu_signed),
        .alu_src_a  (ctl_alu_src_a),
        .alu_src_b  (ctl_alu_src_b),
        .result_src (ctl_result_src),
        .mem_write  (ctl_mem_write),
        .reg_write  (ctl_reg_write),
        .pc_src     (ctl_pc_src),
        .illegal    (ctl_illegal),
        .imm_sel    (ctl_imm_sel)
    );

    assign ctl_in = '{rs1: dec_out.rs1, rs2: dec_out.rs2, rd: dec_out.rd,
                      funct3: dec_out.funct3, mnemonic: dec_out.mnemonic,
                      alu_op: ctl_alu_op, alu_signed: ctl_alu_signed,
                      alu_src_a: ctl_alu_src_a, alu_src_b: ctl_alu_src_b,
                      result_src: ctl_result_src, mem_write: ctl_mem_write,
                      reg_write: ctl_reg_write, pc_src: ctl_pc_src,
                      illegal: ctl_illegal, imm_sel: ctl_imm_sel};

    rv_stage_reg #(.payload_t(control_payload_t)) rv_stage_reg_control_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (ctl_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (ctl_out)
    );

    assign rs1        = ctl_out.rs1;
    assign rs2        = ctl_out.rs2;
    assign rd         = ctl_out.rd;
    assign funct3     = ctl_out.funct3;
    assign mnemonic   = ctl_out.mnemonic;
    assign alu_op     = ctl_out.alu_op;
    assign alu_signed = ctl_out.alu_signed;
    assign alu_src_a  = ctl_out.alu_src_a;
    assign alu_src_b  = ctl_out.alu_src_b;
    assign result_src = ctl_out.result_src;
    assign mem_write  = ctl_out.mem_write;
    assign reg_write  = ctl_out.reg_write;
    assign pc_src     = ctl_out.pc_src;
    assign illegal    = ctl_out.illegal;
    assign imm_sel    = ctl_out.imm_sel;

endmodule

// ==== test/rv_decode_tb.sv ====
`timescale 1ns/1ps

module rv_decode_tb;

    import rv_decode_pkg::*;

    localparam int NUM_VECTORS = 56;
    localparam int FIELDS      = 10;  // values per vector line
    localparam int MAX_CYCLES  = 8 * NUM_VECTORS + 100;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    instr_t    instruction;
    logic      alu_zero;
    logic      alu_slt;
    logic      out_valid;
    logic      out_ready;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    funct3_t   funct3;
    mnemonic_e mnemonic;
    alu_op_e   alu_op;
    logic      alu_signed;
    logic      alu_src_a;
    logic      alu_src_b;
    logic      result_src;
    logic      mem_write;
    logic      reg_write;
    logic      pc_src;
    logic      illegal;
    imm_sel_e  imm_sel;

    logic [31:0] vec_mem [NUM_VECTORS * FIELDS];
    int          accept_edge [NUM_VECTORS];  // edge at which each vector entered the DUT
    int          cycle_count;
    int          send_idx;
    int          check_idx;
    int          last_low_edge;  // most recent edge with out_ready low
    logic        start_driving;

    rv_decode_top rv_decode_top_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .instruction (instruction),
        .alu_zero    (alu_zero),
        .alu_slt     (alu_slt),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .mnemonic    (mnemonic),
        .alu_op      (alu_op),
        .alu_signed  (alu_signed),
        .alu_src_a   (alu_src_a),
        .alu_src_b   (alu_src_b),
        .result_src  (result_src),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .pc_src      (pc_src),
        .illegal     (illegal),
        .imm_sel     (imm_sel)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_reg(string name, reg_idx_t expected, reg_idx_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_funct3(string name, funct3_t expected, funct3_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_mnemonic(string name, mnemonic_e expected, mnemonic_e actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected 0x%h, got 0x%h", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_alu_op(string name, alu_op_e expected, alu_op_e actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_imm_sel(string name, imm_sel_e expected, imm_sel_e actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    task automatic check_cycles(string name, int expected, int actual);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
            abort_run();
        end
    endtask

    // compares the item on the output with vector idx
    task automatic compare_item(int idx);
        int         base;
        logic [7:0] ctrl;
        base = idx * FIELDS;
        ctrl = vec_mem[base + 9][7:0];
        check_reg("rd", reg_idx_t'(vec_mem[base + 2]), rd);
        check_reg("rs1", reg_idx_t'(vec_mem[base + 3]), rs1);
        check_reg("rs2", reg_idx_t'(vec_mem[base + 4]), rs2);
        check_funct3("funct3", funct3_t'(vec_mem[base + 5]), funct3);
        check_mnemonic("mnemonic", mnemonic_e'(vec_mem[base + 6][5:0]), mnemonic);
        check_alu_op("alu_op", alu_op_e'(vec_mem[base + 7][3:0]), alu_op);
        check_imm_sel("imm_sel", imm_sel_e'(vec_mem[base + 8][2:0]), imm_sel);
        check_bit("alu_signed", ctrl[7], alu_signed);
        check_bit("alu_src_a", ctrl[6], alu_src_a);
        check_bit("alu_src_b", ctrl[5], alu_src_b);
        check_bit("result_src", ctrl[4], result_src);
        check_bit("mem_write", ctrl[3], mem_write);
        check_bit("reg_write", ctrl[2], reg_write);
        check_bit("pc_src", ctrl[1], pc_src);
        check_bit("illegal", ctrl[0], illegal);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: not all decoded instructions came out");
            abort_run();
        end
    end

    // input side, with random gaps between items
    always @(posedge clk) begin
        if (start_driving) begin
            if (in_valid && in_ready) begin
                accept_edge[send_idx] = cycle_count;
                send_idx = send_idx + 1;
            end
            if (!in_valid || in_ready) begin  // a stalled item stays as it is
                if (send_idx < NUM_VECTORS && $urandom_range(99) >= 25) begin
                    in_valid    <= 1'b1;
                    instruction <= vec_mem[send_idx * FIELDS];
                    alu_zero    <= vec_mem[send_idx * FIELDS + 1][1];
                    alu_slt     <= vec_mem[send_idx * FIELDS + 1][0];
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // output side, about 30% back-pressure until every vector is through
    always @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else begin
            if (!out_ready) begin
                last_low_edge = cycle_count;
            end
            if (out_valid && out_ready) begin
                if (check_idx >= NUM_VECTORS) begin
                    $display("an extra item came out after the last vector at %0t", $time);
                    abort_run();
                end else begin
                    compare_item(check_idx);
                    if (last_low_edge <= accept_edge[check_idx]) begin
                        check_cycles("latency", 2, cycle_count - accept_edge[check_idx]);
                    end
                    check_idx = check_idx + 1;
                end
            end
            if (check_idx >= NUM_VECTORS) begin
                out_ready <= 1'b1;
            end else begin
                out_ready <= ($urandom_range(99) >= 30);
            end
        end
    end

    initial begin
        void'($urandom(32'h1ed768b8));
        $timeformat(-9, 0, " ns", 0);
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        instruction   = '0;
        alu_zero      = 1'b0;
        alu_slt       = 1'b0;
        out_ready     = 1'b0;
        start_driving = 1'b0;
        cycle_count   = 0;
        send_idx      = 0;
        check_idx     = 0;
        last_low_edge = 0;
        $readmemh("test/rv_decode_vectors.hex", vec_mem);
        if ($isunknown(vec_mem[NUM_VECTORS * FIELDS - 1])) begin
            $display("the vector file is missing or holds fewer vectors than expected");
            abort_run();
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b1, in_ready);
        start_driving <= 1'b1;
        wait (check_idx == NUM_VECTORS);
        repeat (4) @(posedge clk);  // room for a repeated item to show up
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== test/rv_decode_vectors.hex ====
// instr flags(bit1 zero, bit0 slt) rd rs1 rs2 funct3 mnemonic alu_op imm_sel ctrl
// ctrl bits 7..0: alu_signed alu_src_a alu_src_b result_src mem_write reg_write pc_src illegal
003100b3 0 01 02 03 0 00 0 0 04 // add
40628233 3 04 05 06 0 01 1 0 04 // sub
009413b3 0 07 08 09 1 02 2 0 04 // sll
00c5a533 1 0a 0b 0c 2 03 3 0 84 // slt
00f736b3 0 0d 0e 0f 3 04 3 0 04 // sltu
0128c833 2 10 11 12 4 05 4 0 04 // xor
015a59b3 0 13 14 15 5 06 5 0 04 // srl
418bdb33 0 16 17 18 5 07 6 0 04 // sra
01bd6cb3 0 19 1a 1b 6 08 7 0 04 // or
01eefe33 3 1c 1d 1e 7 09 8 0 04 // and
7ff08f93 0 1f 01 1f 0 0a 0 0 24 // addi
00519113 0 02 03 05 1 0b 2 0 24 // slli
fff2a213 1 04 05 1f 2 0c 3 0 a4 // slti
00a3b313 0 06 07 0a 3 0d 3 0 24 // sltiu
0f04c413 0 08 09 10 4 0e 4 0 24 // xori
0035d513 0 0a 0b 03 5 0f 5 0 24 // srli
4076d613 2 0c 0d 07 5 10 6 0 24 // srai
1237e713 0 0e 0f 03 6 11 7 0 24 // ori
0ff8f813 0 10 11 1f 7 12 8 0 24 // andi
01010283 0 05 02 10 0 13 0 0 34 // lb
00442303 3 06 08 04 2 15 0 0 34 // lw
ffc55483 0 09 0a 1c 5 17 0 0 34 // lhu
00320423 0 08 04 03 0 18 0 1 28 // sb
02b12223 2 04 02 0b 2 1a 0 1 28 // sw
123452b7 0 05 08 03 5 23 0 4 24 // lui
00001517 0 0a 00 00 1 24 0 4 64 // auipc
008000ef 0 01 00 08 0 21 0 3 06 // jal
00008067 3 00 01 00 0 22 0 0 26 // jalr
00208463 0 08 01 02 0 1b 1 2 00 // beq
00208463 1 08 01 02 0 1b 1 2 00
00208463 2 08 01 02 0 1b 1 2 02
00208463 3 08 01 02 0 1b 1 2 02
00419463 0 08 03 04 1 1c 1 2 02 // bne
00419463 1 08 03 04 1 1c 1 2 02
00419463 2 08 03 04 1 1c 1 2 00
00419463 3 08 03 04 1 1c 1 2 00
0062c463 0 08 05 06 4 1d 3 2 80 // blt
0062c463 1 08 05 06 4 1d 3 2 82
0062c463 2 08 05 06 4 1d 3 2 80
0062c463 3 08 05 06 4 1d 3 2 82
0083d463 0 08 07 08 5 1e 3 2 82 // bge
0083d463 1 08 07 08 5 1e 3 2 80
0083d463 2 08 07 08 5 1e 3 2 82
0083d463 3 08 07 08 5 1e 3 2 80
00a4e463 0 08 09 0a 6 1f 3 2 00 // bltu
00a4e463 1 08 09 0a 6 1f 3 2 02
00a4e463 2 08 09 0a 6 1f 3 2 00
00a4e463 3 08 09 0a 6 1f 3 2 02
00c5f463 0 08 0b 0c 7 20 3 2 02 // bgeu
00c5f463 1 08 0b 0c 7 20 3 2 00
00c5f463 2 08 0b 0c 7 20 3 2 02
00c5f463 3 08 0b 0c 7 20 3 2 00
00000073 0 00 00 00 0 25 0 0 00 // ecall
00100073 3 00 00 01 0 26 0 0 00 // ebreak
12345a7f 3 14 08 03 5 3f 0 0 01 // unknown opcode
00013083 0 01 02 00 3 3f 0 0 01 // load with unused funct3

// ==== all.f ====
design/rv_decode_pkg.sv
design/rv_stage_reg.sv
design/rv_mnemonic_decoder.sv
design/rv_control_table.sv
design/rv_decode_top.sv
test/rv_decode_tb.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - design/rv_decode_pkg.sv
  - design/rv_stage_reg.sv
  - design/rv_mnemonic_decoder.sv
  - design/rv_control_table.sv
  - design/rv_decode_top.sv
  - target: test
    files:
      - test/rv_decode_tb.sv
